// File: riscvAlu.sv
// ################################################
// Combinational ALU: add, sub, and, or, signed slt
// Unknown codes give zero
// ################################################

module riscvAlu (
    input  logic [riscvPkg::XLen-1:0] a_i,
    input  logic [riscvPkg::XLen-1:0] b_i,
    input  logic [2:0]                aluControl_i,
    output logic [riscvPkg::XLen-1:0] result_o,
    output logic                      zero_o
);
    import riscvPkg::*;

    always_comb begin
        case (aluControl_i)
            AluAdd:  result_o = a_i + b_i;
            AluSub:  result_o = a_i - b_i;
            AluAnd:  result_o = a_i & b_i;
            AluOr:   result_o = a_i | b_i;
            AluSlt:  result_o = {{(XLen-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            default: result_o = '0;
        endcase
    end

    // Branches compare by subtracting
    assign zero_o = (result_o == '0);

endmodule

// File: riscvController.sv
// ################################################
// Main and ALU decoder with E, M and W control registers
// Unknown opcodes decode to a bubble (no write, no jump)
// Control registers reset to bubbles
// ################################################

module riscvController (
    input  logic       clk,
    input  logic       reset,
    input  logic [6:0] opD_i,
    input  logic [2:0] funct3D_i,
    input  logic       funct7b5D_i,
    input  logic       stallD_i,
    input  logic       flushE_i,
    output logic [1:0] immSrcD_o,
    output logic [2:0] aluControlE_o,
    output logic       aluSrcE_o,
    output logic       branchE_o,
    output logic       branchNeE_o,
    output logic       jumpE_o,
    output logic [1:0] resultSrcE_o,
    output logic       memWriteM_o,
    output logic [1:0] resultSrcM_o,
    output logic       regWriteM_o,
    output logic       regWriteW_o,
    output logic [1:0] resultSrcW_o
);
    import riscvPkg::*;

    logic       regWriteD, memWriteD, aluSrcD;
    logic       branchD, branchNeD, jumpD;
    logic [1:0] resultSrcD;
    logic [2:0] aluControlD;
    logic       regWriteE, memWriteE;

    always_comb begin
        regWriteD   = 1'b0;
        memWriteD   = 1'b0;
        aluSrcD     = 1'b0;
        branchD     = 1'b0;
        branchNeD   = 1'b0;
        jumpD       = 1'b0;
        resultSrcD  = ResAlu;
        immSrcD_o   = ImmI;
        aluControlD = AluAdd;
        case (opD_i)
            OpRType, OpIType: begin
                regWriteD = 1'b1;
                aluSrcD   = (opD_i == OpIType);
                case (funct3D_i)
                    Funct3Add: aluControlD = (opD_i == OpRType && funct7b5D_i) ? AluSub : AluAdd;
                    Funct3Slt: aluControlD = AluSlt;
                    Funct3Or:  aluControlD = AluOr;
                    Funct3And: aluControlD = AluAnd;
                    default:   aluControlD = AluAdd;
                endcase
            end
            OpLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = ResMem;
            end
            OpStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSrcD_o = ImmS;
            end
            OpBranch: begin
                immSrcD_o   = ImmB;
                aluControlD = AluSub; // Zero flag means equal
                branchD     = (funct3D_i == Funct3Beq);
                branchNeD   = (funct3D_i == Funct3Bne);
            end
            OpJal: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                immSrcD_o  = ImmJ;
                resultSrcD = ResPc4;
            end
            default: ; // Bubble
        endcase
    end

    // Execute stage, a held decode never issues
    always_ff @(posedge clk or posedge reset) begin
        if (reset || flushE_i || stallD_i) begin
            regWriteE     <= 1'b0;
            memWriteE     <= 1'b0;
            aluSrcE_o     <= 1'b0;
            branchE_o     <= 1'b0;
            branchNeE_o   <= 1'b0;
            jumpE_o       <= 1'b0;
            resultSrcE_o  <= ResAlu;
            aluControlE_o <= AluAdd;
        end else begin
            regWriteE     <= regWriteD;
            memWriteE     <= memWriteD;
            aluSrcE_o     <= aluSrcD;
            branchE_o     <= branchD;
            branchNeE_o   <= branchNeD;
            jumpE_o       <= jumpD;
            resultSrcE_o  <= resultSrcD;
            aluControlE_o <= aluControlD;
        end
    end

    // Memory and writeback stages
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regWriteM_o  <= 1'b0;
            memWriteM_o  <= 1'b0;
            resultSrcM_o <= ResAlu;
            regWriteW_o  <= 1'b0;
            resultSrcW_o <= ResAlu;
        end else begin
            regWriteM_o  <= regWriteE;
            memWriteM_o  <= memWriteE;
            resultSrcM_o <= resultSrcE_o;
            regWriteW_o  <= regWriteM_o;
            resultSrcW_o <= resultSrcM_o;
        end
    end

endmodule

// File: riscvDatapath.sv
// ################################################
// PC, pipeline payload registers, immediates, branches
// Branches resolve in execute, redirect lands one cycle later
// A flushed decode slot holds an all-zero word (bubble)
// ################################################

module riscvDatapath (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stallF_i,
    input  logic                      stallD_i,
    input  logic                      flushD_i,
    input  logic                      flushE_i,
    input  logic [riscvPkg::XLen-1:0] instrF_i,
    output logic [riscvPkg::XLen-1:0] pcF_o,
    input  logic [1:0]                immSrcD_i,
    input  logic [2:0]                aluControlE_i,
    input  logic                      aluSrcE_i,
    input  logic                      branchE_i,
    input  logic                      branchNeE_i,
    input  logic                      jumpE_i,
    input  logic [1:0]                forwardAE_i,
    input  logic [1:0]                forwardBE_i,
    input  logic [1:0]                resultSrcM_i,
    input  logic [1:0]                resultSrcW_i,
    input  logic                      regWriteW_i,
    input  logic [riscvPkg::XLen-1:0] readDataM_i,
    output logic [6:0]                opD_o,
    output logic [2:0]                funct3D_o,
    output logic                      funct7b5D_o,
    output logic [4:0]                rs1D_o,
    output logic [4:0]                rs2D_o,
    output logic [4:0]                rs1E_o,
    output logic [4:0]                rs2E_o,
    output logic [4:0]                rdE_o,
    output logic [4:0]                rdM_o,
    output logic [4:0]                rdW_o,
    output logic                      pcSrcE_o,
    output logic [riscvPkg::XLen-1:0] aluResultM_o,
    output logic [riscvPkg::XLen-1:0] writeDataM_o
);
    import riscvPkg::*;

    logic [XLen-1:0] pcNextF, pcPlus4F;
    logic [XLen-1:0] instrD, pcD, pcPlus4D, immExtD, rd1D, rd2D;
    logic [XLen-1:0] rd1E, rd2E, pcE, pcPlus4E, immExtE;
    logic [XLen-1:0] srcAE, srcBE, writeDataE, aluResultE, pcTargetE;
    logic [XLen-1:0] pcPlus4M, fwdValM;
    logic [XLen-1:0] aluResultW, readDataW, pcPlus4W, resultW;
    logic            zeroE;

    // Fetch
    assign pcPlus4F = pcF_o + XLen'(4);
    assign pcNextF  = pcSrcE_o ? pcTargetE : pcPlus4F;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pcF_o <= ResetVector;
        else if (!stallF_i)
            pcF_o <= pcNextF;
    end

    // Decode
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            instrD <= '0;
        else if (flushD_i)
            instrD <= '0; // Wrong-path slot
        else if (!stallD_i)
            instrD <= instrF_i;
    end

    always_ff @(posedge clk) begin
        if (!stallD_i) begin
            pcD      <= pcF_o;
            pcPlus4D <= pcPlus4F;
        end
    end

    assign opD_o       = instrD[6:0];
    assign funct3D_o   = instrD[14:12];
    assign funct7b5D_o = instrD[30];
    assign rs1D_o      = instrD[19:15];
    assign rs2D_o      = instrD[24:20];

    always_comb begin
        case (immSrcD_i)
            ImmS:    immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            ImmB:    immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            ImmJ:    immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            default: immExtD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    riscvRegFile u_riscvRegFile (
        .clk          (clk),
        .reset        (reset),
        .rs1_i        (rs1D_o),
        .rs2_i        (rs2D_o),
        .rd_i         (rdW_o),
        .writeData_i  (resultW),
        .writeEnable_i(regWriteW_i),
        .readData1_o  (rd1D),
        .readData2_o  (rd2D)
    );

    // Execute, controls are cleared in the controller on a flush
    always_ff @(posedge clk) begin
        rd1E     <= rd1D;
        rd2E     <= rd2D;
        pcE      <= pcD;
        pcPlus4E <= pcPlus4D;
        immExtE  <= immExtD;
        rs1E_o   <= rs1D_o;
        rs2E_o   <= rs2D_o;
        rdE_o    <= flushE_i ? 5'd0 : instrD[11:7];
    end

    // JAL in memory forwards its link value, not the ALU output
    assign fwdValM = (resultSrcM_i == ResPc4) ? pcPlus4M : aluResultM_o;

    always_comb begin
        case (forwardAE_i)
            FwdMem:  srcAE = fwdValM;
            FwdWb:   srcAE = resultW;
            default: srcAE = rd1E;
        endcase
        case (forwardBE_i)
            FwdMem:  writeDataE = fwdValM;
            FwdWb:   writeDataE = resultW;
            default: writeDataE = rd2E;
        endcase
    end

    assign srcBE = aluSrcE_i ? immExtE : writeDataE;

    riscvAlu u_riscvAlu (
        .a_i         (srcAE),
        .b_i         (srcBE),
        .aluControl_i(aluControlE_i),
        .result_o    (aluResultE),
        .zero_o      (zeroE)
    );

    assign pcTargetE = pcE + immExtE; // Same adder for branches and JAL
    assign pcSrcE_o  = jumpE_i | (branchE_i & zeroE) | (branchNeE_i & ~zeroE);

    // Memory and writeback
    always_ff @(posedge clk) begin
        aluResultM_o <= aluResultE;
        writeDataM_o <= writeDataE;
        rdM_o        <= rdE_o;
        pcPlus4M     <= pcPlus4E;
        aluResultW   <= aluResultM_o;
        readDataW    <= readDataM_i;
        rdW_o        <= rdM_o;
        pcPlus4W     <= pcPlus4M;
    end

    always_comb begin
        case (resultSrcW_i)
            ResMem:  resultW = readDataW;
            ResPc4:  resultW = pcPlus4W;
            default: resultW = aluResultW;
        endcase
    end

endmodule

// File: riscvHazardUnit.sv
// ################################################
// Forwarding, load-use stall and flush decisions
// Memory stage wins over writeback, x0 never forwards
// Fetch-not-ready holds F and D and inserts a bubble
// ################################################

module riscvHazardUnit (
    input  logic [4:0] rs1D_i,
    input  logic [4:0] rs2D_i,
    input  logic [4:0] rs1E_i,
    input  logic [4:0] rs2E_i,
    input  logic [4:0] rdE_i,
    input  logic [4:0] rdM_i,
    input  logic [4:0] rdW_i,
    input  logic [1:0] resultSrcE_i,
    input  logic       regWriteM_i,
    input  logic       regWriteW_i,
    input  logic       pcSrcE_i,
    input  logic       readyF_i,
    output logic       stallF_o,
    output logic       stallD_o,
    output logic       flushD_o,
    output logic       flushE_o,
    output logic [1:0] forwardAE_o,
    output logic [1:0] forwardBE_o
);
    import riscvPkg::*;

    logic lwStall;

    function automatic logic [1:0] fwdSel(input logic [4:0] rs);
        if (rs != 5'd0 && regWriteM_i && rs == rdM_i)
            return FwdMem;
        else if (rs != 5'd0 && regWriteW_i && rs == rdW_i)
            return FwdWb;
        else
            return FwdNone;
    endfunction

    always_comb begin
        forwardAE_o = fwdSel(rs1E_i);
        forwardBE_o = fwdSel(rs2E_i);
    end

    // Load in execute feeding the instruction in decode
    assign lwStall = (resultSrcE_i == ResMem) && (rdE_i == rs1D_i || rdE_i == rs2D_i);

    // A redirect must still load the PC while fetch is not ready
    assign stallF_o = lwStall | (~readyF_i & ~pcSrcE_i);
    assign stallD_o = lwStall | ~readyF_i;
    assign flushD_o = pcSrcE_i;
    assign flushE_o = lwStall | pcSrcE_i | ~readyF_i;

endmodule

// File: riscvPipe.sv
// ################################################
// Pipelined RV32I subset core, wiring only
// Instruction fetch is qualified by readyF_i
// Data memory must answer in the same cycle
// ################################################

module riscvPipe (
    input  logic                      clk,
    input  logic                      reset,
    output logic [riscvPkg::XLen-1:0] pcF_o,
    input  logic [riscvPkg::XLen-1:0] instrF_i,
    input  logic                      readyF_i,
    output logic                      memWriteM_o,
    output logic [riscvPkg::XLen-1:0] aluResultM_o,
    output logic [riscvPkg::XLen-1:0] writeDataM_o,
    input  logic [riscvPkg::XLen-1:0] readDataM_i,
    output logic                      mispredict_o
);
    logic       stallF, stallD, flushD, flushE, pcSrcE;
    logic [6:0] opD;
    logic [2:0] funct3D, aluControlE;
    logic       funct7b5D, aluSrcE, branchE, branchNeE, jumpE;
    logic       regWriteM, regWriteW;
    logic [1:0] immSrcD, resultSrcE, resultSrcM, resultSrcW;
    logic [1:0] forwardAE, forwardBE;
    logic [4:0] rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;

    assign mispredict_o = pcSrcE; // Taken branch or jump in execute

    riscvController u_riscvController (
        .clk          (clk),
        .reset        (reset),
        .opD_i        (opD),
        .funct3D_i    (funct3D),
        .funct7b5D_i  (funct7b5D),
        .stallD_i     (stallD),
        .flushE_i     (flushE),
        .immSrcD_o    (immSrcD),
        .aluControlE_o(aluControlE),
        .aluSrcE_o    (aluSrcE),
        .branchE_o    (branchE),
        .branchNeE_o  (branchNeE),
        .jumpE_o      (jumpE),
        .resultSrcE_o (resultSrcE),
        .memWriteM_o  (memWriteM_o),
        .resultSrcM_o (resultSrcM),
        .regWriteM_o  (regWriteM),
        .regWriteW_o  (regWriteW),
        .resultSrcW_o (resultSrcW)
    );

    riscvHazardUnit u_riscvHazardUnit (
        .rs1D_i      (rs1D),
        .rs2D_i      (rs2D),
        .rs1E_i      (rs1E),
        .rs2E_i      (rs2E),
        .rdE_i       (rdE),
        .rdM_i       (rdM),
        .rdW_i       (rdW),
        .resultSrcE_i(resultSrcE),
        .regWriteM_i (regWriteM),
        .regWriteW_i (regWriteW),
        .pcSrcE_i    (pcSrcE),
        .readyF_i    (readyF_i),
        .stallF_o    (stallF),
        .stallD_o    (stallD),
        .flushD_o    (flushD),
        .flushE_o    (flushE),
        .forwardAE_o (forwardAE),
        .forwardBE_o (forwardBE)
    );

    riscvDatapath u_riscvDatapath (
        .clk          (clk),
        .reset        (reset),
        .stallF_i     (stallF),
        .stallD_i     (stallD),
        .flushD_i     (flushD),
        .flushE_i     (flushE),
        .instrF_i     (instrF_i),
        .pcF_o        (pcF_o),
        .immSrcD_i    (immSrcD),
        .aluControlE_i(aluControlE),
        .aluSrcE_i    (aluSrcE),
        .branchE_i    (branchE),
        .branchNeE_i  (branchNeE),
        .jumpE_i      (jumpE),
        .forwardAE_i  (forwardAE),
        .forwardBE_i  (forwardBE),
        .resultSrcM_i (resultSrcM),
        .resultSrcW_i (resultSrcW),
        .regWriteW_i  (regWriteW),
        .readDataM_i  (readDataM_i),
        .opD_o        (opD),
        .funct3D_o    (funct3D),
        .funct7b5D_o  (funct7b5D),
        .rs1D_o       (rs1D),
        .rs2D_o       (rs2D),
        .rs1E_o       (rs1E),
        .rs2E_o       (rs2E),
        .rdE_o        (rdE),
        .rdM_o        (rdM),
        .rdW_o        (rdW),
        .pcSrcE_o     (pcSrcE),
        .aluResultM_o (aluResultM_o),
        .writeDataM_o (writeDataM_o)
    );

endmodule

// File: riscvPipeTb.sv
// ################################################
// Run from the project root so riscvVectors.txt is found
// Vector file holds the program, FFFFFFFF, store pairs and FFFFFFFF
// Both memories are 64 words and the program must fit
// The program has to end in a self loop after its last store
// ################################################

module riscvPipeTb;

    localparam int          ClkPeriod = 10;
    localparam int          ResetCycles = 8;
    localparam int          VecDepth = 128;
    localparam int          MemWords = 64;
    localparam logic [31:0] Separator = 32'hFFFF_FFFF;

    logic        clk;
    logic        reset;
    logic [31:0] pcF;
    logic [31:0] instrF;
    logic        readyF;
    logic        memWriteM;
    logic [31:0] aluResultM;
    logic [31:0] writeDataM;
    logic [31:0] readDataM;
    logic        mispredict;

    logic [31:0] vecMem [0:VecDepth-1]; // Raw vector file
    logic [31:0] imem [0:MemWords-1];
    logic [31:0] dmem [0:MemWords-1];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    int          progWords;
    int          storeIdx = 0;           // Next expected store
    int          seed;
    bit          loaded;

    riscvPipe u_riscvPipe (
        .clk         (clk),
        .reset       (reset),
        .pcF_o       (pcF),
        .instrF_i    (instrF),
        .readyF_i    (readyF),
        .memWriteM_o (memWriteM),
        .aluResultM_o(aluResultM),
        .writeDataM_o(writeDataM),
        .readDataM_i (readDataM),
        .mispredict_o(mispredict)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Both memory models answer in the same cycle
    assign instrF    = imem[pcF[7:2]];
    assign readDataM = dmem[aluResultM[7:2]];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MemWords; i++)
                dmem[i] <= 32'hD000_0000 | 32'(i);
        end else if (memWriteM) begin
            dmem[aluResultM[7:2]] <= writeDataM; // Store commits here
        end
    end

    // Fetch ready is low about one cycle in four
    initial begin
        seed   = 32'h6333a82b;
        readyF = 1'b1;
        forever begin
            @(negedge clk);
            readyF = ($random(seed) & 3) != 0;
        end
    end

    task automatic loadVectors();
        int idx;
        for (int i = 0; i < MemWords; i++)
            imem[i] = 32'h0000_0013 | (32'(i) << 20); // ADDI x0, x0, i
        $readmemh("riscvVectors.txt", vecMem);
        idx = 0;
        while (idx < MemWords && vecMem[idx] !== Separator) begin
            imem[idx] = vecMem[idx];
            idx++;
        end
        progWords = idx;
        idx++; // Skip separator
        while (idx + 1 < VecDepth && vecMem[idx] !== Separator) begin
            expAddr.push_back(vecMem[idx]);
            expData.push_back(vecMem[idx + 1]);
            idx += 2;
        end
        if (progWords == 0 || expAddr.size() == 0) begin
            $display("The vector file holds no program or no expected stores");
            $display("Simulation failed");
            $fatal(1, "Vector file unusable");
        end
    endtask

    task automatic checkResetState();
        assert (pcF == 32'h0 && memWriteM == 1'b0 && mispredict == 1'b0)
        else begin
            $display("FAILED at %0t: in reset pcF_o=%h memWriteM_o=%b mispredict_o=%b, %s",
                     $time, pcF, memWriteM, mispredict, "expected all zero");
            $display("Simulation failed");
            $fatal(1, "Reset state wrong");
        end
    endtask

    task automatic compareStore();
        if (storeIdx >= expAddr.size()) begin
            $display("A store of %h to address %h came after the last expected store",
                     writeDataM, aluResultM);
            $display("Simulation failed");
            $fatal(1, "Unexpected store");
        end else begin
            assert (aluResultM == expAddr[storeIdx] && writeDataM == expData[storeIdx])
            else begin
                $display("FAILED at %0t: store %0d wrote %h to %h, expected %h to %h",
                         $time, storeIdx, writeDataM, aluResultM,
                         expData[storeIdx], expAddr[storeIdx]);
                $display("Simulation failed");
                $fatal(1, "Store mismatch");
            end
            storeIdx++;
        end
    endtask

    // Each store is seen once while memWriteM_o is high
    always @(negedge clk) begin
        if (memWriteM)
            compareStore();
    end

    // Allows twice 40 cycles per program word for fetch stalls
    initial begin
        wait (loaded);
        #(ClkPeriod * (ResetCycles + progWords * 40 * 2));
        $display("Timeout: the program did not finish, %0d of %0d stores seen",
                 storeIdx, expAddr.size());
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int loopHits;
        reset    = 1'b1;
        loopHits = 0;
        loadVectors();
        loaded = 1'b1;
        repeat (ResetCycles) begin
            @(negedge clk);
            checkResetState();
        end
        reset = 1'b0;
        wait (storeIdx == expAddr.size());
        // Closing self loop goes round twice so a stray store still shows
        while (loopHits < 2) begin
            @(negedge clk);
            if (mispredict)
                loopHits++;
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: riscvPkg.sv
// ################################################
// Encodings for the reduced RV32I core
// Only ADD SUB AND OR SLT ADDI LW SW BEQ BNE JAL decode
// Select codes are shared by controller, hazard unit and datapath
// ################################################

package riscvPkg;

    localparam int XLen = 32;
    localparam logic [31:0] ResetVector = 32'h0000_0000;

    // Major opcodes
    localparam logic [6:0] OpRType  = 7'b0110011;
    localparam logic [6:0] OpIType  = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;

    // funct3 values
    localparam logic [2:0] Funct3Add = 3'b000; // ADD, SUB and ADDI
    localparam logic [2:0] Funct3Slt = 3'b010;
    localparam logic [2:0] Funct3Or  = 3'b110;
    localparam logic [2:0] Funct3And = 3'b111;
    localparam logic [2:0] Funct3Beq = 3'b000;
    localparam logic [2:0] Funct3Bne = 3'b001;

    // ALU operations
    localparam logic [2:0] AluAdd = 3'b000;
    localparam logic [2:0] AluSub = 3'b001;
    localparam logic [2:0] AluAnd = 3'b010;
    localparam logic [2:0] AluOr  = 3'b011;
    localparam logic [2:0] AluSlt = 3'b101;

    // Immediate formats
    localparam logic [1:0] ImmI = 2'b00;
    localparam logic [1:0] ImmS = 2'b01;
    localparam logic [1:0] ImmB = 2'b10;
    localparam logic [1:0] ImmJ = 2'b11;

    // Writeback result source
    localparam logic [1:0] ResAlu = 2'b00;
    localparam logic [1:0] ResMem = 2'b01;
    localparam logic [1:0] ResPc4 = 2'b10; // JAL link value

    // Execute operand forwarding
    localparam logic [1:0] FwdNone = 2'b00;
    localparam logic [1:0] FwdWb   = 2'b01;
    localparam logic [1:0] FwdMem  = 2'b10;

endpackage

// File: riscvRegFile.sv
// ################################################
// 32 x XLen register file, x0 reads as zero
// A write in the same cycle bypasses to both read ports
// ################################################

module riscvRegFile (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [4:0]                rs1_i,
    input  logic [4:0]                rs2_i,
    input  logic [4:0]                rd_i,
    input  logic [riscvPkg::XLen-1:0] writeData_i,
    input  logic                      writeEnable_i,
    output logic [riscvPkg::XLen-1:0] readData1_o,
    output logic [riscvPkg::XLen-1:0] readData2_o
);
    import riscvPkg::*;

    logic [XLen-1:0] regs [1:31]; // No storage for x0

    function automatic logic [XLen-1:0] readReg(input logic [4:0] rs);
        if (rs == 5'd0)
            return '0;
        else if (writeEnable_i && rs == rd_i)
            return writeData_i; // Writeback overlaps decode
        else
            return regs[rs];
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (writeEnable_i && rd_i != 5'd0) begin
            regs[rd_i] <= writeData_i;
        end
    end

    always_comb begin
        readData1_o = readReg(rs1_i);
        readData2_o = readReg(rs2_i);
    end

endmodule

// File: riscvVectors.txt
// Program words in address order from 0, one 32-bit hex word each, then FFFFFFFF
// Then expected stores in program order, columns: address data, then FFFFFFFF
// Dependent ALU chain x1=5 x2=12 x3=17 x4=12 x5=13 x6=1, stores to 0x0C 0x00 0x04 0x08
00500093 00708113 002081B3 40118233 001262B3 0032F333
00602623 00302023 00402223 00502423
// LW x7 then ADDI x8 at once, LW x9 then SW of x9
00402383 06438413 00802823 01002483 00902A23
// BEQ taken over markers at 0x18 0x1C, BNE and BEQ not taken, BNE taken over 0x28
00220663 00102C23 00102E23 00221463 02202023
00208463 02102223 00209463 02202423
// JAL x10 over a marker at 0x2C, then link value stored to 0x30
0080056F 02102623 02A02823
// SLT with x11=-3 x12=2 x15=-7
FFD00593 00200613 00C5A6B3 00B62733 FF900793 00B7A833
02D02A23 02E02C23 03002E23
// ADDI to x0, x0 read back by ADD and SW, then x11 stored
06308013 001008B3 05102023 04002223 04B02423
// Self loop
0000006F
FFFFFFFF
0000000C 00000001
00000000 00000011
00000004 0000000C
00000008 0000000D
00000010 00000070
00000014 00000070
00000020 0000000C
00000024 00000005
00000030 00000064
00000034 00000001
00000038 00000000
0000003C 00000001
00000040 00000005
00000044 00000000
00000048 FFFFFFFD
FFFFFFFF

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# The exit status of the simulation is the result of the run.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --top-module riscvPipeTb \
    -f sources.f \
    -o riscvPipeSim
./obj_dir/riscvPipeSim

// File: sources.f
riscvPkg.sv
riscvRegFile.sv
riscvAlu.sv
riscvHazardUnit.sv
riscvController.sv
riscvDatapath.sv
riscvPipe.sv
riscvPipeTb.sv
